// ==== Makefile ====
VERILATOR = verilator
TOP       = tb_eeprom_ctrl
LINT_TOP  = eeprom_ctrl_top
FILELIST  = files.f
VFLAGS    = --binary --timing --assert -j 0
LINTFLAGS = --lint-only --timing
OBJ_DIR   = obj_dir
PASS_MSG  = No errors

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== eeprom_byte_sequencer.sv ====
`timescale 1ns/100ps
module eeprom_byte_sequencer
    import eeprom_host_pkg::*, two_wire_pkg::*;
(
    input  logic              CLK,
    input  logic              RESET,
    input  logic              req_valid,
    output logic              req_ready,
    input  eeprom_op_e        req_op,
    input  logic [ADDR_W-1:0] req_addr,
    input  logic [DATA_W-1:0] req_wdata,
    output logic              sym_valid,
    input  logic              sym_ready,
    output bit_cmd_e          sym_cmd,
    output logic [7:0]        sym_byte,
    input  logic              done_valid,
    input  logic [7:0]        done_byte,
    input  logic              done_nack,
    output logic              res_valid,
    input  logic              res_ready,
    output logic [DATA_W-1:0] res_rdata,
    output logic              res_nack
);

    seq_state_e        state;
    seq_state_e        next_state;
    eeprom_op_e        op;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic              sym_busy;   // symbol handed over, done not yet seen
    logic              ack_state;  // states where the slave acknowledges

    assign req_ready = (state == IDLE);
    assign res_valid = (state == DONE);
    assign sym_valid = (state != IDLE) && (state != DONE) && !sym_busy;
    assign ack_state = (state == CTRL_WR) || (state == ADDR) ||
                       (state == DATA_WR) || (state == CTRL_RD);

    always_comb
    begin
        sym_cmd  = SYM_WRITE;
        sym_byte = 8'hff;
        case (state)
            START, RESTART: sym_cmd = SYM_START;
            CTRL_WR:        sym_byte = {CTRL_PREFIX, addr[ADDR_W-1:8], 1'b0};
            ADDR:           sym_byte = addr[7:0];
            DATA_WR:        sym_byte = wdata;
            CTRL_RD:        sym_byte = {CTRL_PREFIX, addr[ADDR_W-1:8], 1'b1};
            DATA_RD:        sym_cmd = SYM_READ;
            STOP:           sym_cmd = SYM_STOP;
            default:        sym_cmd = SYM_WRITE;
        endcase
    end

    // nack on any written byte jumps to stop
    always_comb
    begin
        next_state = STOP;
        case (state)
            START:   next_state = CTRL_WR;
            CTRL_WR: next_state = done_nack ? STOP : ADDR;
            ADDR:
                if (!done_nack)
                    next_state = (op == OP_WRITE) ? DATA_WR : RESTART;
            RESTART: next_state = CTRL_RD;
            CTRL_RD: next_state = done_nack ? STOP : DATA_RD;
            STOP:    next_state = DONE;
            default: next_state = STOP;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state    <= IDLE;
            sym_busy <= 1'b0;
        end
        else
        begin
            if (sym_valid && sym_ready)
                sym_busy <= 1'b1;
            else if (done_valid)
                sym_busy <= 1'b0;

            case (state)
                IDLE:    if (req_valid) state <= START;
                DONE:    if (res_ready) state <= IDLE;
                default: if (done_valid) state <= next_state;
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (req_valid && req_ready)
        begin
            op        <= req_op;
            addr      <= req_addr;
            wdata     <= req_wdata;
            res_rdata <= '0;  // stays zero unless a byte comes back
            res_nack  <= 1'b0;
        end
        else if (done_valid)
        begin
            if (ack_state && done_nack)
                res_nack <= 1'b1;
            if (state == DATA_RD)
                res_rdata <= done_byte;
        end
    end

    // engine must be idle whenever a new symbol is offered
    assert property (@(posedge CLK) disable iff (RESET) sym_valid |-> sym_ready)
    else
        $error("symbol offered while engine busy");

endmodule

// ==== eeprom_cmd_stage.sv ====
`timescale 1ns/100ps
module eeprom_cmd_stage
    import eeprom_host_pkg::*;
(
    input  logic              CLK,
    input  logic              RESET,
    input  logic              cmd_valid,
    output logic              cmd_ready,
    input  eeprom_op_e        cmd_op,
    input  logic [ADDR_W-1:0] cmd_addr,
    input  logic [DATA_W-1:0] cmd_wdata,
    output logic              req_valid,
    input  logic              req_ready,
    output eeprom_op_e        req_op,
    output logic [ADDR_W-1:0] req_addr,
    output logic [DATA_W-1:0] req_wdata
);

    // free slot, or the held command leaves this cycle
    assign cmd_ready = !req_valid || req_ready;

    always_ff @(posedge CLK)
    begin
        if (RESET)
            req_valid <= 1'b0;
        else if (cmd_ready)
            req_valid <= cmd_valid;
    end

    always_ff @(posedge CLK)
    begin
        if (cmd_valid && cmd_ready)
        begin
            req_op    <= cmd_op;
            req_addr  <= cmd_addr;
            req_wdata <= cmd_wdata;
        end
    end

    // held command must not move under a stalled sequencer
    assert property (@(posedge CLK) disable iff (RESET)
        req_valid && !req_ready |=> $stable(req_op))
    else
        $error("req_op changed while stalled");

endmodule

// ==== eeprom_ctrl_top.sv ====
`timescale 1ns/100ps
module eeprom_ctrl_top
    import eeprom_host_pkg::*, two_wire_pkg::*;
#(
    parameter int SCL_HALF = 2
)
(
    input  logic              CLK,
    input  logic              RESET,
    input  logic              cmd_valid,
    output logic              cmd_ready,
    input  eeprom_op_e        cmd_op,
    input  logic [ADDR_W-1:0] cmd_addr,
    input  logic [DATA_W-1:0] cmd_wdata,
    output logic              rsp_valid,
    input  logic              rsp_ready,
    output logic [DATA_W-1:0] rsp_rdata,
    output logic              rsp_nack,
    output logic              scl,
    output logic              sda_drive_low,
    input  logic              sda_in
);

    logic              req_valid;
    logic              req_ready;
    eeprom_op_e        req_op;
    logic [ADDR_W-1:0] req_addr;
    logic [DATA_W-1:0] req_wdata;
    logic              sym_valid;
    logic              sym_ready;
    bit_cmd_e          sym_cmd;
    logic [7:0]        sym_byte;
    logic              done_valid;
    logic [7:0]        done_byte;
    logic              done_nack;
    logic              res_valid;
    logic              res_ready;
    logic [DATA_W-1:0] res_rdata;
    logic              res_nack;

    eeprom_cmd_stage u_cmd
    (
        .CLK       (CLK),
        .RESET     (RESET),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd_op    (cmd_op),
        .cmd_addr  (cmd_addr),
        .cmd_wdata (cmd_wdata),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req_op    (req_op),
        .req_addr  (req_addr),
        .req_wdata (req_wdata)
    );

    eeprom_byte_sequencer u_seq
    (
        .CLK        (CLK),
        .RESET      (RESET),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req_op     (req_op),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .sym_valid  (sym_valid),
        .sym_ready  (sym_ready),
        .sym_cmd    (sym_cmd),
        .sym_byte   (sym_byte),
        .done_valid (done_valid),
        .done_byte  (done_byte),
        .done_nack  (done_nack),
        .res_valid  (res_valid),
        .res_ready  (res_ready),
        .res_rdata  (res_rdata),
        .res_nack   (res_nack)
    );

    two_wire_bit_engine #(.SCL_HALF(SCL_HALF)) u_bit
    (
        .CLK           (CLK),
        .RESET         (RESET),
        .sym_valid     (sym_valid),
        .sym_ready     (sym_ready),
        .sym_cmd       (sym_cmd),
        .sym_byte      (sym_byte),
        .done_valid    (done_valid),
        .done_byte     (done_byte),
        .done_nack     (done_nack),
        .scl           (scl),
        .sda_drive_low (sda_drive_low),
        .sda_in        (sda_in)
    );

    eeprom_rsp_stage u_rsp
    (
        .CLK       (CLK),
        .RESET     (RESET),
        .res_valid (res_valid),
        .res_ready (res_ready),
        .res_rdata (res_rdata),
        .res_nack  (res_nack),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp_rdata (rsp_rdata),
        .rsp_nack  (rsp_nack)
    );

endmodule

// ==== eeprom_host_pkg.sv ====
package eeprom_host_pkg;

    // 16-kbit part, 2048 bytes
    localparam int ADDR_W = 11;
    localparam int DATA_W = 8;

    // host command opcode
    typedef enum logic
    {
        OP_WRITE = 1'b0,
        OP_READ  = 1'b1
    } eeprom_op_e;

endpackage

// ==== eeprom_rsp_stage.sv ====
`timescale 1ns/100ps
module eeprom_rsp_stage
    import eeprom_host_pkg::*;
(
    input  logic              CLK,
    input  logic              RESET,
    input  logic              res_valid,
    output logic              res_ready,
    input  logic [DATA_W-1:0] res_rdata,
    input  logic              res_nack,
    output logic              rsp_valid,
    input  logic              rsp_ready,
    output logic [DATA_W-1:0] rsp_rdata,
    output logic              rsp_nack
);

    assign res_ready = !rsp_valid || rsp_ready;

    always_ff @(posedge CLK)
    begin
        if (RESET)
            rsp_valid <= 1'b0;
        else if (res_ready)
            rsp_valid <= res_valid;
    end

    always_ff @(posedge CLK)
    begin
        if (res_valid && res_ready)
        begin
            rsp_rdata <= res_rdata;
            rsp_nack  <= res_nack;
        end
    end

    assert property (@(posedge CLK) disable iff (RESET)
        rsp_valid && !rsp_ready |=> $stable(rsp_rdata))
    else
        $error("response data moved while host stalled");

endmodule

// ==== files.f ====
eeprom_host_pkg.sv
two_wire_pkg.sv
eeprom_cmd_stage.sv
eeprom_byte_sequencer.sv
two_wire_bit_engine.sv
eeprom_rsp_stage.sv
eeprom_ctrl_top.sv
tb_clock_gen.sv
tb_eeprom_model.sv
tb_eeprom_ctrl.sv

// ==== tb_clock_gen.sv ====
`timescale 1ns/100ps
module tb_clock_gen
(
    output logic CLK,
    output logic RESET
);

    initial
    begin
        CLK   = 1'b0;
        RESET = 1'b1;
    end

    always #20 CLK = ~CLK;  // 40 ns period

    initial
    begin
        repeat (8) @(posedge CLK);
        @(negedge CLK);
        RESET = 1'b0;
    end

endmodule

// ==== tb_eeprom_ctrl.sv ====
`timescale 1ns/100ps
module tb_eeprom_ctrl
    import eeprom_host_pkg::*;
;

    localparam int WAIT_LIMIT = 2000;

    logic              CLK;
    logic              RESET;
    logic              cmd_valid;
    logic              cmd_ready;
    eeprom_op_e        cmd_op;
    logic [ADDR_W-1:0] cmd_addr;
    logic [DATA_W-1:0] cmd_wdata;
    logic              rsp_valid;
    logic              rsp_ready;
    logic [DATA_W-1:0] rsp_rdata;
    logic              rsp_nack;
    logic              scl;
    logic              sda_drive_low;
    logic              sda_in;
    logic              model_low;
    logic              force_nack;

    logic [DATA_W-1:0] ref_mem [0:2047];
    logic [DATA_W-1:0] exp_rdata_arr [0:255];
    logic              exp_nack_arr [0:255];
    logic [7:0]        push_idx;
    logic [7:0]        issued;
    logic [7:0]        taken;
    logic [DATA_W-1:0] exp_rdata;
    logic              exp_nack;
    logic              bus_open = 1'b0;
    logic              armed = 1'b0;
    int                scl_rises = 0;   // scl rising edges since reset
    int                frame_mark = 0;  // scl_rises at the last start or stop
    int                errors = 0;
    int                seed;
    logic [ADDR_W-1:0] a;
    logic [ADDR_W-1:0] a2;
    logic [DATA_W-1:0] d;

    tb_clock_gen u_clk (.CLK(CLK), .RESET(RESET));

    eeprom_ctrl_top #(.SCL_HALF(2)) u_dut
    (
        .CLK           (CLK),
        .RESET         (RESET),
        .cmd_valid     (cmd_valid),
        .cmd_ready     (cmd_ready),
        .cmd_op        (cmd_op),
        .cmd_addr      (cmd_addr),
        .cmd_wdata     (cmd_wdata),
        .rsp_valid     (rsp_valid),
        .rsp_ready     (rsp_ready),
        .rsp_rdata     (rsp_rdata),
        .rsp_nack      (rsp_nack),
        .scl           (scl),
        .sda_drive_low (sda_drive_low),
        .sda_in        (sda_in)
    );

    // wired-AND with pull-up
    assign sda_in = !(sda_drive_low || model_low);

    tb_eeprom_model u_eeprom
    (
        .scl           (scl),
        .sda           (sda_in),
        .force_nack    (force_nack),
        .sda_drive_low (model_low)
    );

    assign exp_rdata = exp_rdata_arr[taken];
    assign exp_nack  = exp_nack_arr[taken];

    always_ff @(posedge CLK)
    begin
        armed <= 1'b1;
        if (RESET)
        begin
            issued <= '0;
            taken  <= '0;
        end
        else
        begin
            issued <= issued + 8'(cmd_valid && cmd_ready);
            taken  <= taken + 8'(rsp_valid && rsp_ready);
        end
    end

    task automatic report_value(input string name, input logic [7:0] got, input logic [7:0] exp);
        errors++;
        $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
    endtask

    task automatic report_fail(input string what);
        errors++;
        $display("failure at %0t: %s", $time, what);
    endtask

    task automatic timed_out(input string what);
        $display("timeout at %0t: %s", $time, what);
        $display("Errors found");
        $finish;
    endtask

    always @(posedge scl)
    begin
        if (RESET === 1'b0)
            scl_rises++;
    end

    // start or stop only on a byte boundary, each byte is nine scl clocks
    always @(sda_in)
    begin
        if (scl === 1'b1 && RESET === 1'b0)
        begin
            if (bus_open)
            begin
                assert (scl_rises - frame_mark >= 10 && (scl_rises - frame_mark) % 9 == 1)
                else
                    report_fail("start or stop in the middle of a byte");
            end
            else
            begin
                assert (sda_in === 1'b0 && scl_rises - frame_mark == 1)
                else
                    report_fail("sda moved under scl high on an idle bus");
            end
            bus_open   = (sda_in === 1'b0);  // start opens, stop closes
            frame_mark = scl_rises;
        end
    end

    assert property (@(posedge CLK) armed && $past(RESET) |-> cmd_ready)
    else report_value("cmd_ready", 8'($sampled(cmd_ready)), 8'd1);
    assert property (@(posedge CLK) armed && $past(RESET) |-> !rsp_valid)
    else report_value("rsp_valid", 8'($sampled(rsp_valid)), 8'd0);
    assert property (@(posedge CLK) armed && $past(RESET) |-> scl)
    else report_value("scl", 8'($sampled(scl)), 8'd1);
    assert property (@(posedge CLK) armed && $past(RESET) |-> !sda_drive_low)
    else report_value("sda_drive_low", 8'($sampled(sda_drive_low)), 8'd0);

    assert property (@(posedge CLK) disable iff (RESET)
        rsp_valid && rsp_ready |-> rsp_rdata == exp_rdata)
    else report_value("rsp_rdata", $sampled(rsp_rdata), $sampled(exp_rdata));
    assert property (@(posedge CLK) disable iff (RESET)
        rsp_valid && rsp_ready |-> rsp_nack == exp_nack)
    else report_value("rsp_nack", 8'($sampled(rsp_nack)), 8'($sampled(exp_nack)));

    assert property (@(posedge CLK) disable iff (RESET)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_rdata) && $stable(rsp_nack))
    else report_fail("response moved or vanished while the host stalled it");
    assert property (@(posedge CLK) disable iff (RESET) issued - taken == 8'd3 |-> !cmd_ready)
    else report_fail("cmd_ready high with three commands in flight");

    assert property (@(posedge CLK) disable iff (RESET) rsp_valid && rsp_ready |-> !bus_open)
    else report_fail("response taken before the bus saw a stop");

    task automatic issue(input eeprom_op_e op, input logic [10:0] addr, input logic [7:0] wdata);
        int n;
        n = 0;
        if (force_nack)
        begin
            exp_rdata_arr[push_idx] = '0;
            exp_nack_arr[push_idx]  = 1'b1;
        end
        else
        begin
            if (op == OP_WRITE)
                ref_mem[addr] = wdata;
            exp_rdata_arr[push_idx] = (op == OP_WRITE) ? 8'h00 : ref_mem[addr];
            exp_nack_arr[push_idx]  = 1'b0;
        end
        push_idx  = push_idx + 1'b1;
        cmd_valid = 1'b1;
        cmd_op    = op;
        cmd_addr  = addr;
        cmd_wdata = wdata;
        while (!cmd_ready && n < WAIT_LIMIT)
        begin
            @(negedge CLK);
            n++;
        end
        if (!cmd_ready)
            timed_out("cmd_ready stayed low");
        @(negedge CLK);
        cmd_valid = 1'b0;
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (taken != push_idx && n < WAIT_LIMIT)
        begin
            @(negedge CLK);
            n++;
        end
        if (taken != push_idx)
            timed_out("responses missing");
    endtask

    initial
    begin
        seed       = 32'h39ac8716;
        cmd_valid  = 1'b0;
        cmd_op     = OP_WRITE;
        cmd_addr   = '0;
        cmd_wdata  = '0;
        rsp_ready  = 1'b1;
        force_nack = 1'b0;
        push_idx   = '0;
        for (int n = 0; RESET !== 1'b0 && n < 100; n++)
            @(negedge CLK);
        if (RESET !== 1'b0)
            timed_out("reset never released");
        @(negedge CLK);

        repeat (4)
        begin
            a = 11'($random(seed));
            d = 8'($random(seed));
            issue(OP_WRITE, a, d);
            issue(OP_READ, a, 8'h00);
            drain();
        end

        // same word address in every block
        a = 11'($random(seed));
        d = 8'($random(seed));
        for (int b = 0; b < 8; b++)
            issue(OP_WRITE, {3'(b), a[7:0]}, d ^ 8'(b * 37));
        for (int b = 0; b < 8; b++)
            issue(OP_READ, {3'(b), a[7:0]}, 8'h00);
        drain();

        force_nack = 1'b1;
        issue(OP_WRITE, a, ~d);
        drain();
        issue(OP_READ, a, 8'h00);
        drain();
        force_nack = 1'b0;
        issue(OP_READ, a, 8'h00);  // old contents survive
        drain();

        rsp_ready = 1'b0;
        a2 = 11'($random(seed));
        issue(OP_WRITE, a2, 8'($random(seed)));
        issue(OP_READ, a2, 8'h00);
        issue(OP_WRITE, a2 ^ 11'h400, 8'($random(seed)));
        repeat (400) @(negedge CLK);
        rsp_ready = 1'b1;
        drain();
        issue(OP_READ, a2 ^ 11'h400, 8'h00);
        drain();

        @(negedge CLK);
        $display("checks finished with %0d errors", errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

// ==== tb_eeprom_model.sv ====
`timescale 1ns/100ps
module tb_eeprom_model
    import two_wire_pkg::*;
(
    input  logic scl,
    input  logic sda,
    input  logic force_nack,
    output logic sda_drive_low
);

    typedef enum logic [2:0] {M_IDLE, M_CTRL, M_ADDR, M_WDATA, M_READ, M_SKIP} phase_e;

    logic [7:0] mem [0:2047];
    phase_e     phase;
    phase_e     next_phase;
    logic [7:0] shreg;
    logic [2:0] block;
    logic [7:0] word;
    logic       scl_q;
    logic       sda_q;
    logic       ack;
    int         bit_cnt;  // 9 marks the ack slot

    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[i] = 8'(i) ^ 8'(i >> 3) ^ 8'h5a;
        phase         = M_IDLE;
        next_phase    = M_IDLE;
        shreg         = '0;
        block         = '0;
        word          = '0;
        bit_cnt       = 0;
        sda_drive_low = 1'b0;
        scl_q         = 1'b1;
        sda_q         = 1'b1;
    end

    always @(scl or sda)
    begin
        if (scl === 1'b1 && scl_q === 1'b1 && sda !== sda_q && sda_q !== 1'bx)
        begin
            phase   = (sda === 1'b0) ? M_CTRL : M_IDLE;  // start or stop
            bit_cnt = 0;
        end
        else if (scl === 1'b1 && scl_q === 1'b0)
        begin
            if (phase != M_IDLE && phase != M_SKIP && bit_cnt < 8)
            begin
                shreg   = (phase == M_READ) ? shreg : {shreg[6:0], sda};
                bit_cnt = bit_cnt + 1;
            end
        end
        else if (scl === 1'b0 && scl_q === 1'b1)
        begin
            if (bit_cnt == 9)
            begin
                sda_drive_low = 1'b0;
                bit_cnt       = 0;
                phase         = next_phase;
                if (phase == M_READ)
                begin
                    shreg         = mem[{block, word}];
                    sda_drive_low = !shreg[7];
                end
            end
            else if (phase == M_READ && bit_cnt > 0 && bit_cnt < 8)
                sda_drive_low = !shreg[7 - bit_cnt];
            else if (phase == M_READ && bit_cnt == 8)
            begin
                sda_drive_low = 1'b0;  // master owns this ack
                next_phase    = M_SKIP;
                bit_cnt       = 9;
            end
            else if (bit_cnt == 8 && phase inside {M_CTRL, M_ADDR, M_WDATA})
            begin
                ack = !force_nack;
                case (phase)
                    M_CTRL:
                    begin
                        ack        = ack && (shreg[7:4] == CTRL_PREFIX);
                        block      = shreg[3:1];
                        next_phase = shreg[0] ? M_READ : M_ADDR;
                    end
                    M_ADDR:
                    begin
                        word       = shreg;
                        next_phase = M_WDATA;
                    end
                    default:
                    begin
                        if (ack)
                            mem[{block, word}] = shreg;
                        next_phase = M_SKIP;  // single byte writes only
                    end
                endcase
                if (!ack)
                    next_phase = M_SKIP;
                sda_drive_low = ack;
                bit_cnt       = 9;
            end
        end
        scl_q = scl;
        sda_q = sda;
    end

endmodule

// ==== two_wire_bit_engine.sv ====
`timescale 1ns/100ps
module two_wire_bit_engine
    import two_wire_pkg::*;
#(
    parameter int SCL_HALF = 2
)
(
    input  logic       CLK,
    input  logic       RESET,
    input  logic       sym_valid,
    output logic       sym_ready,
    input  bit_cmd_e   sym_cmd,
    input  logic [7:0] sym_byte,
    output logic       done_valid,
    output logic [7:0] done_byte,
    output logic       done_nack,
    output logic       scl,
    output logic       sda_drive_low,
    input  logic       sda_in
);

    localparam int PH_W = $clog2(SCL_HALF);

    bit_cmd_e        cmd;
    logic            busy;
    logic            high_half;  // second half of the scl period
    logic [PH_W-1:0] ph_cnt;
    logic [3:0]      bit_cnt;    // 8 is the acknowledge slot
    logic [7:0]      shreg;
    logic            ack_bit;
    logic            half_end;
    logic            framing;    // start or stop
    logic            last_slot;
    logic            sda_next;

    assign sym_ready = !busy;
    assign half_end  = (ph_cnt == PH_W'(SCL_HALF - 1));
    assign framing   = (cmd == SYM_START) || (cmd == SYM_STOP);
    assign last_slot = framing || (bit_cnt == 4'd8);

    always_comb
    begin
        sda_next = sda_drive_low;
        case (cmd)
            SYM_START: sda_next = high_half;   // falls under scl high
            SYM_STOP:  sda_next = !high_half;  // rises under scl high
            SYM_WRITE:
                if (!high_half)
                    sda_next = (bit_cnt != 4'd8) && !shreg[7];
            default:
                if (!high_half)
                    sda_next = 1'b0;  // read bits and the final nack released
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            busy          <= 1'b0;
            high_half     <= 1'b0;
            ph_cnt        <= '0;
            bit_cnt       <= '0;
            scl           <= 1'b1;
            sda_drive_low <= 1'b0;
            done_valid    <= 1'b0;
        end
        else
        begin
            done_valid <= 1'b0;
            if (!busy)
            begin
                if (sym_valid)
                begin
                    busy      <= 1'b1;
                    high_half <= 1'b0;
                    ph_cnt    <= '0;
                    bit_cnt   <= '0;
                    scl       <= 1'b0;  // each slot opens low
                end
            end
            else
            begin
                ph_cnt <= half_end ? '0 : ph_cnt + 1'b1;
                if (ph_cnt == '0)
                    sda_drive_low <= sda_next;
                if (half_end)
                begin
                    if (!high_half)
                    begin
                        high_half <= 1'b1;
                        scl       <= 1'b1;
                    end
                    else if (last_slot)
                    begin
                        busy       <= 1'b0;
                        done_valid <= 1'b1;
                    end
                    else
                    begin
                        high_half <= 1'b0;
                        scl       <= 1'b0;
                        bit_cnt   <= bit_cnt + 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (!busy && sym_valid)
        begin
            cmd   <= sym_cmd;
            shreg <= sym_byte;
        end
        else if (busy && half_end && !high_half)
        begin
            // sample on the scl rising point
            if (bit_cnt == 4'd8)
                ack_bit <= sda_in;
            else
                shreg <= {shreg[6:0], sda_in};
        end
        if (busy && half_end && high_half && last_slot)
        begin
            done_byte <= shreg;
            done_nack <= !framing && ack_bit;
        end
    end

    assert property (@(posedge CLK) disable iff (RESET)
        busy && !framing && $changed(sda_drive_low) |-> !scl)
    else
        $error("sda moved with scl high inside a byte");

endmodule

// ==== two_wire_pkg.sv ====
package two_wire_pkg;

    localparam logic [3:0] CTRL_PREFIX = 4'b1010;  // device type code

    // symbols the sequencer asks of the bit engine
    typedef enum logic [1:0]
    {
        SYM_START = 2'd0,
        SYM_STOP  = 2'd1,
        SYM_WRITE = 2'd2,
        SYM_READ  = 2'd3
    } bit_cmd_e;

    typedef enum logic [3:0]
    {
        IDLE    = 4'd0,
        START   = 4'd1,
        CTRL_WR = 4'd2,
        ADDR    = 4'd3,
        DATA_WR = 4'd4,
        RESTART = 4'd5,
        CTRL_RD = 4'd6,
        DATA_RD = 4'd7,
        STOP    = 4'd8,
        DONE    = 4'd9
    } seq_state_e;

endpackage
